//--- hdl/video_pkg.sv
package video_pkg;

    // pixel clock enable, one pulse every pxl_div clocks
    localparam int pxl_div = 4;
    localparam int div_w   = (pxl_div > 1) ? $clog2(pxl_div) : 1;

    // raster size in pixels and lines
    localparam int h_total  = 48;
    localparam int h_active = 32;
    localparam int v_total  = 20;
    localparam int v_active = 16;

    localparam int h_w = $clog2(h_total);  // hcount width
    localparam int v_w = $clog2(v_total);  // vcount width

    // palette prom geometry
    localparam int pal_aw    = 5;
    localparam int pal_dw    = 8;
    localparam int pal_depth = 2 ** pal_aw;

    // layer pixel width, 0 is transparent
    localparam int pxl_w = 4;

    // index reg, prom read and blank reg
    // also the blanking delay in pixel enables
    localparam int colmix_dly = 3;

endpackage

//--- hdl/video_timing.sv
module video_timing (
    input  logic                        clk,
    input  logic                        rst_n,
    output logic                        pxl_cen,
    output logic [video_pkg::h_w-1:0]   hcount,
    output logic [video_pkg::v_w-1:0]   vcount,
    output logic                        lhbl,
    output logic                        lvbl
);

    logic [video_pkg::div_w-1:0] div_cnt;  // clocks within the current pixel
    logic                        div_last;

    logic [video_pkg::h_w-1:0]   h_next;
    logic [video_pkg::v_w-1:0]   v_next;
    logic                        h_wrap;   // last pixel of the line
    logic                        v_wrap;   // last line of the frame

    assign div_last = div_cnt == video_pkg::div_w'(video_pkg::pxl_div - 1);

    // pxl_cen is registered so it comes out clean
    // first pulse lands pxl_div clocks after reset release
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            div_cnt <= '0;
            pxl_cen <= 1'b0;
        end else begin
            pxl_cen <= div_last;
            if (div_last) begin
                div_cnt <= '0;
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end
        end
    end

    assign h_wrap = hcount == video_pkg::h_w'(video_pkg::h_total - 1);
    assign v_wrap = vcount == video_pkg::v_w'(video_pkg::v_total - 1);

    // next counter values, shared by the counters and the blanking compares
    always_comb begin
        if (h_wrap) begin
            h_next = '0;
        end else begin
            h_next = hcount + 1'b1;
        end
    end

    always_comb begin
        if (!h_wrap) begin
            v_next = vcount;       // vertical only steps at the line wrap
        end else if (v_wrap) begin
            v_next = '0;
        end else begin
            v_next = vcount + 1'b1;
        end
    end

    // counters and blanking move together on pxl_cen
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hcount <= '0;
            vcount <= '0;
            lhbl   <= 1'b0;
            lvbl   <= 1'b0;
        end else if (pxl_cen) begin
            hcount <= h_next;
            vcount <= v_next;
            // compare on next values so the flags match the counters
            lhbl   <= h_next < video_pkg::h_w'(video_pkg::h_active);
            lvbl   <= v_next < video_pkg::v_w'(video_pkg::v_active);
        end
    end

endmodule

//--- hdl/palette_prom.sv
module palette_prom (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          cen,
    input  logic [video_pkg::pal_aw-1:0]  wr_addr,
    input  logic [video_pkg::pal_dw-1:0]  data,
    input  logic                          we,
    input  logic [video_pkg::pal_aw-1:0]  rd_addr,
    output logic [video_pkg::pal_dw-1:0]  q
);

    // palette array, contents come from the load port only
    logic [video_pkg::pal_dw-1:0] mem [0:video_pkg::pal_depth-1];

    // write port runs at full clock rate
    always_ff @(posedge clk) begin
        if (we) begin
            mem[wr_addr] <= data;
        end
    end

    // read register only loads on the pixel enable
    // same address collision returns the old byte
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            q <= '0;
        end else if (cen) begin
            q <= mem[rd_addr];
        end
    end

endmodule

//--- hdl/blank_delay.sv
module blank_delay (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          pxl_cen,
    input  logic                          lhbl,
    input  logic                          lvbl,
    input  logic [video_pkg::pal_dw-1:0]  rgb_in,
    output logic                          lhbl_dly,
    output logic                          lvbl_dly,
    output logic [video_pkg::pal_dw-1:0]  rgb_out
);

    // one bit per pixel enable, oldest at the top
    logic [video_pkg::colmix_dly-1:0] hbl_sr;
    logic [video_pkg::colmix_dly-1:0] vbl_sr;
    logic                             show;

    // blanking of the pixel now arriving on rgb_in
    // it sits one stage short of the output end of the line
    assign show = hbl_sr[video_pkg::colmix_dly-2] & vbl_sr[video_pkg::colmix_dly-2];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hbl_sr  <= '0;
            vbl_sr  <= '0;
            rgb_out <= '0;
        end else if (pxl_cen) begin
            hbl_sr <= {hbl_sr[video_pkg::colmix_dly-2:0], lhbl};
            vbl_sr <= {vbl_sr[video_pkg::colmix_dly-2:0], lvbl};
            // black outside the active area
            if (show) begin
                rgb_out <= rgb_in;
            end else begin
                rgb_out <= '0;
            end
        end
    end

    // outputs change on the same enable as rgb_out
    assign lhbl_dly = hbl_sr[video_pkg::colmix_dly-1];
    assign lvbl_dly = vbl_sr[video_pkg::colmix_dly-1];

endmodule

//--- hdl/colmix.sv
module colmix (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          pxl_cen,
    input  logic [video_pkg::pxl_w-1:0]   obj_pxl,
    input  logic [video_pkg::pxl_w-1:0]   scr_pxl,
    input  logic [1:0]                    layer_en,   // bit 1 objects, bit 0 scroll
    input  logic                          lhbl,
    input  logic                          lvbl,
    input  logic [video_pkg::pal_dw-1:0]  prog_data,
    input  logic [video_pkg::pal_aw-1:0]  prog_addr,
    input  logic                          prog_en,
    output logic [3:0]                    red,
    output logic [3:0]                    green,
    output logic [3:0]                    blue,
    output logic                          lhbl_dly,
    output logic                          lvbl_dly
);

    logic                          obj_blank;  // object transparent or masked
    logic [video_pkg::pxl_w-1:0]   scr_gated;
    logic [video_pkg::pal_aw-1:0]  pal_idx;
    logic [video_pkg::pal_dw-1:0]  pal_raw;    // prom output, not yet blanked
    logic [video_pkg::pal_dw-1:0]  rgb;

    // objects win when opaque and enabled
    assign obj_blank = (obj_pxl == '0) || !layer_en[1];
    assign scr_gated = layer_en[0] ? scr_pxl : '0;

    // stage 1, palette index
    // upper half of the palette belongs to the scroll layer
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pal_idx <= '0;
        end else if (pxl_cen) begin
            if (obj_blank) begin
                pal_idx <= {1'b1, scr_gated};
            end else begin
                pal_idx <= {1'b0, obj_pxl};
            end
        end
    end

    // stage 2, palette read
    palette_prom u_pal (
        .clk     (clk),
        .rst_n   (rst_n),
        .cen     (pxl_cen),
        .wr_addr (prog_addr),
        .data    (prog_data),
        .we      (prog_en),
        .rd_addr (pal_idx),
        .q       (pal_raw)
    );

    // stage 3, blanking
    blank_delay u_blank (
        .clk      (clk),
        .rst_n    (rst_n),
        .pxl_cen  (pxl_cen),
        .lhbl     (lhbl),
        .lvbl     (lvbl),
        .rgb_in   (pal_raw),
        .lhbl_dly (lhbl_dly),
        .lvbl_dly (lvbl_dly),
        .rgb_out  (rgb)
    );

    // packed byte is bbgggrrr
    // widen to 4 bits each by repeating the top bits
    assign red   = {rgb[2:0], rgb[2]};
    assign green = {rgb[5:3], rgb[5]};
    assign blue  = {2{rgb[7:6]}};

endmodule

//--- hdl/video_top.sv
module video_top (
    input  logic                          clk,
    input  logic                          rst_n,

    // layer pixels from the tile and sprite generators
    input  logic [video_pkg::pxl_w-1:0]   obj_pxl,
    input  logic [video_pkg::pxl_w-1:0]   scr_pxl,
    input  logic [1:0]                    layer_en,

    // palette load port
    input  logic                          prog_en,
    input  logic [video_pkg::pal_aw-1:0]  prog_addr,
    input  logic [video_pkg::pal_dw-1:0]  prog_data,

    // raster position, for the layer generators
    output logic                          pxl_cen,
    output logic [video_pkg::h_w-1:0]     hcount,
    output logic [video_pkg::v_w-1:0]     vcount,
    output logic                          lhbl,
    output logic                          lvbl,

    // final video
    output logic [3:0]                    red,
    output logic [3:0]                    green,
    output logic [3:0]                    blue,
    output logic                          lhbl_dly,
    output logic                          lvbl_dly
);

    video_timing u_timing (
        .clk     (clk),
        .rst_n   (rst_n),
        .pxl_cen (pxl_cen),
        .hcount  (hcount),
        .vcount  (vcount),
        .lhbl    (lhbl),
        .lvbl    (lvbl)
    );

    // colour pipeline runs off the same pixel enable
    colmix u_colmix (
        .clk       (clk),
        .rst_n     (rst_n),
        .pxl_cen   (pxl_cen),
        .obj_pxl   (obj_pxl),
        .scr_pxl   (scr_pxl),
        .layer_en  (layer_en),
        .lhbl      (lhbl),
        .lvbl      (lvbl),
        .prog_data (prog_data),
        .prog_addr (prog_addr),
        .prog_en   (prog_en),
        .red       (red),
        .green     (green),
        .blue      (blue),
        .lhbl_dly  (lhbl_dly),
        .lvbl_dly  (lvbl_dly)
    );

endmodule

//--- tb/tb_tasks.svh
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

// compare and stop at the first mismatch
task automatic check_eq(input string name, input logic [31:0] expected,
                        input logic [31:0] actual);
    if (actual !== expected) begin
        $display("FAILED t=%0.1f ns %s expected 0x%0h actual 0x%0h",
                 $realtime, name, expected, actual);
        $display("Done: errors found");
        $fatal(1, "value mismatch");
    end
endtask

// pixel enables seen by the DUT up to the last rising edge
// first enable edge comes pxl_div + 1 clocks after release
function automatic int model_enables();
    if (clk_idx < 1) begin
        return 0;
    end
    return (clk_idx - 1) / video_pkg::pxl_div;
endfunction

function automatic logic model_lhbl(input int n);
    return (n >= 1) && ((n % video_pkg::h_total) < video_pkg::h_active);
endfunction

function automatic logic model_lvbl(input int n);
    return (n >= 1) && (((n / video_pkg::h_total) % video_pkg::v_total) < video_pkg::v_active);
endfunction

// palette entry picked by the layer rules
function automatic int model_index(input logic [video_pkg::pxl_w-1:0] obj,
                                   input logic [video_pkg::pxl_w-1:0] scr,
                                   input logic [1:0] en);
    if (obj != '0 && en[1]) begin
        return int'(obj);                         // objects use the lower half
    end else if (en[0]) begin
        return video_pkg::pal_depth / 2 + int'(scr);
    end
    return video_pkg::pal_depth / 2;              // scroll off gives entry 16
endfunction

// bbgggrrr to 4 bits per component packed as {r, g, b}
function automatic logic [11:0] expand_colour(input logic [video_pkg::pal_dw-1:0] pal);
    logic [3:0] r;
    logic [3:0] g;
    logic [3:0] b;
    r = {pal[2:0], pal[2]};
    g = {pal[5:3], pal[5]};
    b = {pal[7:6], pal[7:6]};
    return {r, g, b};
endfunction

function automatic logic [video_pkg::pxl_w-1:0] rand_pxl();
    return video_pkg::pxl_w'($urandom);
endfunction

function automatic logic [video_pkg::pxl_w-1:0] rand_opaque();
    return video_pkg::pxl_w'(1 + ($urandom % 15));   // never transparent
endfunction

// returns 1 ns after the next rising edge with pxl_cen high
task automatic next_pixel();
    @(negedge clk);
    while (pxl_cen !== 1'b1) begin
        @(negedge clk);
    end
    @(posedge clk);
    #1;
endtask

task automatic check_out();
    logic [11:0] exp_rgb;
    logic [1:0]  exp_bl;
    exp_rgb = exp_rgb_q.pop_front();
    exp_bl  = exp_bl_q.pop_front();
    check_eq("lhbl_dly", 32'(exp_bl[1]), 32'(lhbl_dly));
    check_eq("lvbl_dly", 32'(exp_bl[0]), 32'(lvbl_dly));
    check_eq("red", 32'(exp_rgb[11:8]), 32'(red));
    check_eq("green", 32'(exp_rgb[7:4]), 32'(green));
    check_eq("blue", 32'(exp_rgb[3:0]), 32'(blue));
    if (!(lhbl_dly && lvbl_dly)) begin
        blank_seen = blank_seen + 1;
    end
endtask

// one pixel in and the one from colmix_dly enables back out
task automatic drive_pixel(input logic [video_pkg::pxl_w-1:0] obj,
                           input logic [video_pkg::pxl_w-1:0] scr,
                           input logic [1:0] en);
    int          n;
    logic        lh;
    logic        lv;
    logic [11:0] colour;
    next_pixel();
    if (exp_rgb_q.size() >= video_pkg::colmix_dly) begin
        check_out();
    end
    obj_pxl  = obj;
    scr_pxl  = scr;
    layer_en = en;
    n  = model_enables();
    lh = model_lhbl(n);          // blanking that travels with this pixel
    lv = model_lvbl(n);
    if (lh && lv) begin
        colour = expand_colour(pal_model[model_index(obj, scr, en)]);
    end else begin
        colour = '0;
    end
    exp_rgb_q.push_back(colour);
    exp_bl_q.push_back({lh, lv});
endtask

task automatic drain_pixels();
    while (exp_rgb_q.size() > 0) begin
        next_pixel();
        check_out();
    end
endtask

// full rate writes with no handshake
task automatic load_palette();
    logic [video_pkg::pal_dw-1:0] entry_val;
    int                           i;
    for (i = 0; i < video_pkg::pal_depth; i++) begin
        entry_val    = video_pkg::pal_dw'($urandom);
        pal_model[i] = entry_val;
        @(posedge clk);
        #1;
        prog_en   = 1'b1;
        prog_addr = video_pkg::pal_aw'(i);
        prog_data = entry_val;
    end
    @(posedge clk);
    #1;
    prog_en = 1'b0;
endtask

task automatic check_quiet_outputs();
    check_eq("lhbl", 0, 32'(lhbl));
    check_eq("lvbl", 0, 32'(lvbl));
    check_eq("hcount", 0, 32'(hcount));
    check_eq("vcount", 0, 32'(vcount));
    check_eq("lhbl_dly", 0, 32'(lhbl_dly));
    check_eq("lvbl_dly", 0, 32'(lvbl_dly));
    check_eq("red", 0, 32'(red));
    check_eq("green", 0, 32'(green));
    check_eq("blue", 0, 32'(blue));
endtask

task automatic test_reset();
    int clocks;
    rst_n = 1'b0;
    repeat (8) begin
        @(posedge clk);
        #1;
        check_eq("pxl_cen", 0, 32'(pxl_cen));
        check_quiet_outputs();
    end
    rst_n = 1'b1;
    // pxl_cen must rise exactly pxl_div clocks after release
    for (clocks = 1; clocks <= video_pkg::pxl_div; clocks++) begin
        @(posedge clk);
        #1;
        check_eq("pxl_cen", 32'(clocks == video_pkg::pxl_div), 32'(pxl_cen));
        check_quiet_outputs();
    end
endtask

task automatic test_raster();
    int   n;
    int   hi_h;
    int   hi_v;
    logic prev_lvbl;
    // pulse train at clock level first
    repeat (4 * video_pkg::pxl_div) begin
        @(posedge clk);
        #1;
        check_eq("pxl_cen", 32'(clk_idx % video_pkg::pxl_div == 0), 32'(pxl_cen));
    end
    hi_h      = 0;
    hi_v      = 0;
    prev_lvbl = lvbl;
    // any window of one frame holds a whole raster period
    repeat (video_pkg::h_total * video_pkg::v_total) begin
        next_pixel();
        n = model_enables();
        check_eq("hcount", 32'(n % video_pkg::h_total), 32'(hcount));
        check_eq("vcount", 32'((n / video_pkg::h_total) % video_pkg::v_total), 32'(vcount));
        check_eq("lhbl", 32'(model_lhbl(n)), 32'(lhbl));
        check_eq("lvbl", 32'(model_lvbl(n)), 32'(lvbl));
        if (lvbl != prev_lvbl) begin
            check_eq("hcount at lvbl edge", 0, 32'(hcount));
        end
        prev_lvbl = lvbl;
        hi_h      = hi_h + int'(lhbl);
        hi_v      = hi_v + int'(lvbl);
    end
    check_eq("lhbl high count", 32'(video_pkg::v_total * video_pkg::h_active), 32'(hi_h));
    check_eq("lvbl high count", 32'(video_pkg::v_active * video_pkg::h_total), 32'(hi_v));
endtask

task automatic test_palette_scroll();
    load_palette();
    repeat (400) begin
        drive_pixel('0, rand_pxl(), 2'b11);   // objects transparent
    end
    drain_pixels();
endtask

task automatic test_priority();
    logic [video_pkg::pxl_w-1:0] obj;
    repeat (400) begin
        if ($urandom % 4 == 0) begin
            obj = '0;                 // extra transparent objects
        end else begin
            obj = rand_pxl();
        end
        drive_pixel(obj, rand_pxl(), 2'b11);
    end
    drain_pixels();
endtask

task automatic test_layer_enables();
    logic [video_pkg::pxl_w-1:0] obj;
    repeat (200) begin
        drive_pixel(rand_opaque(), rand_pxl(), 2'b01);   // objects masked
    end
    repeat (200) begin
        if ($urandom % 2 == 0) begin
            obj = '0;                 // falls through to entry 16
        end else begin
            obj = rand_opaque();
        end
        drive_pixel(obj, rand_pxl(), 2'b10);   // scroll masked
    end
    repeat (60) begin
        drive_pixel(rand_opaque(), rand_pxl(), 2'b00);
    end
    drain_pixels();
endtask

// nonzero pixels across a whole frame where blanked ones come out black
task automatic test_blanking();
    blank_seen = 0;
    repeat (video_pkg::h_total * video_pkg::v_total) begin
        drive_pixel(rand_opaque(), rand_opaque(), 2'b11);
    end
    drain_pixels();
    check_eq("blanked pixels",
             32'(video_pkg::h_total * video_pkg::v_total
                 - video_pkg::h_active * video_pkg::v_active),
             32'(blank_seen));
endtask

`endif

//--- tb/tb_video_top.sv
module tb_video_top;

    timeunit 1ns;
    timeprecision 100ps;

    logic                           clk;
    logic                           rst_n;

    // layer pixels and enables
    logic [video_pkg::pxl_w-1:0]    obj_pxl;
    logic [video_pkg::pxl_w-1:0]    scr_pxl;
    logic [1:0]                     layer_en;

    // palette load port
    logic                           prog_en;
    logic [video_pkg::pal_aw-1:0]   prog_addr;
    logic [video_pkg::pal_dw-1:0]   prog_data;

    // DUT outputs
    logic                           pxl_cen;
    logic [video_pkg::h_w-1:0]      hcount;
    logic [video_pkg::v_w-1:0]      vcount;
    logic                           lhbl;
    logic                           lvbl;
    logic [3:0]                     red;
    logic [3:0]                     green;
    logic [3:0]                     blue;
    logic                           lhbl_dly;
    logic                           lvbl_dly;

    int clk_idx = 0;      // index of the next rising edge since reset release
    int blank_seen = 0;   // checked pixels that came out blanked

    // shadow copy of the palette contents
    logic [video_pkg::pal_dw-1:0] pal_model [0:video_pkg::pal_depth-1];

    // expected colour and blanking, one entry per pixel in flight
    logic [11:0] exp_rgb_q [$];
    logic [1:0]  exp_bl_q  [$];

    `include "tb_tasks.svh"

    video_top UUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .obj_pxl   (obj_pxl),
        .scr_pxl   (scr_pxl),
        .layer_en  (layer_en),
        .prog_en   (prog_en),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .pxl_cen   (pxl_cen),
        .hcount    (hcount),
        .vcount    (vcount),
        .lhbl      (lhbl),
        .lvbl      (lvbl),
        .red       (red),
        .green     (green),
        .blue      (blue),
        .lhbl_dly  (lhbl_dly),
        .lvbl_dly  (lvbl_dly)
    );

    // 8 ns clock
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // clock count for the raster model, bumped half a cycle ahead of the edge
    always @(negedge clk) begin
        if (!rst_n) begin
            clk_idx <= 0;
        end else begin
            clk_idx <= clk_idx + 1;
        end
    end

    // about four frames of tests, twice that before giving up
    initial begin
        #(2 * 4 * video_pkg::v_total * video_pkg::h_total * video_pkg::pxl_div * 8);
        $display("timeout: the tests did not finish before the watchdog expired");
        $display("Done: errors found");
        $fatal(1, "watchdog expired");
    end

    initial begin
        rst_n     = 1'b0;
        obj_pxl   = '0;
        scr_pxl   = '0;
        layer_en  = 2'b00;
        prog_en   = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        void'($urandom(32'hfcce_0657));   // single seed for the whole run

        test_reset();
        test_raster();
        test_palette_scroll();
        test_priority();
        test_layer_enables();
        test_blanking();

        $display("Done: no errors");
        $finish;
    end

endmodule

//--- build.f
+incdir+tb
hdl/video_pkg.sv
hdl/video_timing.sv
hdl/palette_prom.sv
hdl/blank_delay.sv
hdl/colmix.sv
hdl/video_top.sv
tb/tb_video_top.sv

//--- run.sh
#!/bin/sh
# build the video back end testbench with verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/100ps \
    --top-module tb_video_top \
    -f build.f \
    -Mdir obj_dir -o tb_video_top
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "verilator build failed with status $build_status"
    exit 1
fi

./obj_dir/tb_video_top
sim_status=$?
if [ $sim_status -ne 0 ]; then
    echo "simulation failed with status $sim_status"
    exit 1
fi

echo "simulation finished cleanly"
exit 0
